// File: Bender.yml
package:
  name: z8core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/z8IsaPkg.sv
      - hdl/z8CorePkg.sv
      - hdl/z8Alu.sv
      - hdl/z8RegFile.sv
      - hdl/z8ProgCounter.sv
      - hdl/z8Sequencer.sv
      - hdl/z8Core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/z8CoreTb_properties.sv
      - test/z8CoreTb.sv

// File: hdl/z8Alu.sv
`timescale 1ns/1ps
`default_nettype none

module z8Alu (
    input  wire z8IsaPkg::aluOpT  aluOp,
    input  wire z8CorePkg::byteT  a,
    input  wire z8CorePkg::byteT  b,
    input  wire z8CorePkg::byteT  flagsIn,
    output z8CorePkg::byteT       result,
    output z8CorePkg::byteT       flagsOut
);
    import z8IsaPkg::*;

    logic [8:0] sum;
    logic       carryIn;
    logic       updatesZs;

    assign carryIn = flagsIn[flagC] & (aluOp == aluAdc || aluOp == aluSbc);

    // ld and the carry ops leave Z and S alone
    assign updatesZs = !(aluOp inside {aluLd, aluScf, aluRcf, aluCcf});

    always_comb begin
        sum      = 9'h0;
        result   = a;
        flagsOut = flagsIn;
        case (aluOp)
            aluAdd, aluAdc: begin
                sum             = {1'b0, a} + {1'b0, b} + {8'h0, carryIn};
                result          = sum[7:0];
                flagsOut[flagC] = sum[8];
                flagsOut[flagV] = (a[7] == b[7]) && (sum[7] != a[7]);
            end
            aluSub, aluSbc, aluCp: begin
                // dst minus src, C is the borrow
                sum             = {1'b0, a} - {1'b0, b} - {8'h0, carryIn};
                result          = sum[7:0];
                flagsOut[flagC] = sum[8];
                flagsOut[flagV] = (a[7] != b[7]) && (sum[7] != a[7]);
            end
            aluOr: begin
                result          = a | b;
                flagsOut[flagV] = 1'b0;
            end
            aluAnd: begin
                result          = a & b;
                flagsOut[flagV] = 1'b0;
            end
            aluXor: begin
                result          = a ^ b;
                flagsOut[flagV] = 1'b0;
            end
            aluInc: begin
                result          = a + 8'h1;
                flagsOut[flagV] = (a == 8'h7F);
            end
            aluDec: begin
                result          = a - 8'h1;
                flagsOut[flagV] = (a == 8'h80);
            end
            aluScf: begin
                flagsOut[flagC] = 1'b1;
            end
            aluRcf: begin
                flagsOut[flagC] = 1'b0;
            end
            aluCcf: begin
                flagsOut[flagC] = ~flagsIn[flagC];
            end
            default: begin
                result = a;
            end
        endcase

        if (updatesZs) begin
            flagsOut[flagZ] = (result == 8'h0);
            flagsOut[flagS] = result[7];
        end
    end

endmodule

`default_nettype wire

// File: hdl/z8Core.sv
`timescale 1ns/1ps
`default_nettype none

module z8Core (
    input  wire                  clk,
    input  wire                  rstN,
    input  wire z8CorePkg::byteT progData,
    output z8CorePkg::progAddrT  progAddr,
    output logic                 progStrobe,
    output z8CorePkg::byteT      port2
);
    import z8CorePkg::*;
    import z8IsaPkg::*;

    logic    pcIncr;
    logic    pcBranch;
    logic    wrEn;
    logic    flagsWr;
    byteT    branchOffset;
    byteT    rdDataA;
    byteT    rdDataB;
    byteT    flags;
    byteT    aluA;
    byteT    aluB;
    byteT    aluResult;
    byteT    aluFlags;
    regAddrT rdAddrA;
    regAddrT rdAddrB;
    regAddrT wrAddr;
    aluOpT   aluOp;

    z8Sequencer sequencer_i (
        .clk          (clk),
        .rstN         (rstN),
        .progData     (progData),
        .flags        (flags),
        .rdDataA      (rdDataA),
        .rdDataB      (rdDataB),
        .aluResult    (aluResult),
        .progStrobe   (progStrobe),
        .pcIncr       (pcIncr),
        .pcBranch     (pcBranch),
        .branchOffset (branchOffset),
        .rdAddrA      (rdAddrA),
        .rdAddrB      (rdAddrB),
        .wrAddr       (wrAddr),
        .wrEn         (wrEn),
        .flagsWr      (flagsWr),
        .aluA         (aluA),
        .aluB         (aluB),
        .aluOp        (aluOp)
    );

    // fetch address comes straight from the pc
    z8ProgCounter progCounter_i (
        .clk          (clk),
        .rstN         (rstN),
        .pcIncr       (pcIncr),
        .pcBranch     (pcBranch),
        .branchOffset (branchOffset),
        .pc           (progAddr)
    );

    z8RegFile regFile_i (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (aluResult),
        .flagsWr (flagsWr),
        .flagsIn (aluFlags),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .flags   (flags),
        .port2   (port2)
    );

    z8Alu alu_i (
        .aluOp    (aluOp),
        .a        (aluA),
        .b        (aluB),
        .flagsIn  (flags),
        .result   (aluResult),
        .flagsOut (aluFlags)
    );

endmodule

`default_nettype wire

// File: hdl/z8CorePkg.sv
`default_nettype none

`include "z8core_defines.svh"

package z8CorePkg;

    typedef logic [7:0] byteT;
    typedef logic [3:0] nibbleT;
    typedef logic [`Z8_PROG_ADDR_WIDTH-1:0] progAddrT;

    // register address as encoded in the instruction
    typedef logic [7:0] regAddrT;

    typedef enum logic [3:0] {
        fetch,
        readInstr,
        wait2,
        read2,
        wait3,
        read3,
        decode,
        aluOp1,
        aluOp2,
        aluOp3,
        incOp,
        djnzDec,
        djnzBranch
    } seqStateT;

endpackage

`default_nettype wire

// File: hdl/z8IsaPkg.sv
`default_nettype none

package z8IsaPkg;

    // two-operand codes equal the opcode high nibble
    typedef enum logic [3:0] {
        aluAdd = 4'h0,
        aluAdc = 4'h1,
        aluSub = 4'h2,
        aluSbc = 4'h3,
        aluOr  = 4'h4,
        aluAnd = 4'h5,
        aluInc = 4'h6,
        aluDec = 4'h7,
        aluLd  = 4'h8,
        aluScf = 4'h9,
        aluCp  = 4'hA,
        aluXor = 4'hB,
        aluRcf = 4'hC,
        aluCcf = 4'hD
    } aluOpT;

    // jr condition codes, bit 3 inverts the lower eight
    typedef enum logic [3:0] {
        ccFalse, ccLt, ccLe, ccUle, ccOv, ccMi, ccZ, ccC,
        ccTrue, ccGe, ccGt, ccUgt, ccNov, ccPl, ccNz, ccNc
    } condCodeT;

    typedef enum logic [2:0] {
        flagV = 3'd4,
        flagS = 3'd5,
        flagZ = 3'd6,
        flagC = 3'd7
    } flagIdxT;

    // opcode low nibble columns
    localparam logic [3:0] colAluRR = 4'h2;
    localparam logic [3:0] colDjnz  = 4'hA;
    localparam logic [3:0] colJr    = 4'hB;
    localparam logic [3:0] colLdIm  = 4'hC;
    localparam logic [3:0] colInc   = 4'hE;
    localparam logic [3:0] colMisc  = 4'hF;

    // ld R,#im
    localparam logic [7:0] opLdRIm = 8'hE6;

    // high nibbles of the carry flag ops in column F
    localparam logic [3:0] miscRcf = 4'hC;
    localparam logic [3:0] miscScf = 4'hD;
    localparam logic [3:0] miscCcf = 4'hE;

endpackage

`default_nettype wire

// File: hdl/z8ProgCounter.sv
`timescale 1ns/1ps
`default_nettype none

`include "z8core_defines.svh"

module z8ProgCounter (
    input  wire                  clk,
    input  wire                  rstN,
    input  wire                  pcIncr,
    input  wire                  pcBranch,
    input  wire z8CorePkg::byteT branchOffset,
    output z8CorePkg::progAddrT  pc
);
    import z8CorePkg::*;

    progAddrT offsetExt;

    // relative offset is signed
    assign offsetExt = {{(`Z8_PROG_ADDR_WIDTH - 8){branchOffset[7]}}, branchOffset};

    // pc already points past the jr or djnz when the branch is applied
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `Z8_RESET_PC;
        end else if (pcBranch) begin
            pc <= pc + offsetExt;
        end else if (pcIncr) begin
            pc <= pc + progAddrT'(1);
        end
    end

endmodule

`default_nettype wire

// File: hdl/z8RegFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "z8core_defines.svh"

module z8RegFile (
    input  wire                     clk,
    input  wire                     rstN,
    input  wire z8CorePkg::regAddrT rdAddrA,
    input  wire z8CorePkg::regAddrT rdAddrB,
    input  wire                     wrEn,
    input  wire z8CorePkg::regAddrT wrAddr,
    input  wire z8CorePkg::byteT    wrData,
    input  wire                     flagsWr,
    input  wire z8CorePkg::byteT    flagsIn,
    output z8CorePkg::byteT         rdDataA,
    output z8CorePkg::byteT         rdDataB,
    output z8CorePkg::byteT         flags,
    output z8CorePkg::byteT         port2
);
    import z8CorePkg::*;

    localparam int regIdxWidth = $clog2(`Z8_REG_COUNT);

    byteT    regs [0:`Z8_REG_COUNT-1];
    nibbleT  rp;
    regAddrT wrAddrMapped;

    // E-prefixed address picks a working register through RP
    function automatic regAddrT mapAddr(regAddrT addr, nibbleT rpVal);
        if (addr[7:4] == `Z8_WORKING_PREFIX) begin
            return {rpVal, addr[3:0]};
        end
        return addr;
    endfunction

    function automatic byteT readReg(regAddrT addr);
        byteT data;
        if (addr < `Z8_REG_COUNT) begin
            data = regs[addr[regIdxWidth-1:0]];
        end else if (addr == `Z8_FLAGS_REG) begin
            data = flags;
        end else if (addr == `Z8_RP_REG) begin
            data = {rp, 4'h0};
        end else begin
            data = 8'h0;
        end
        return data;
    endfunction

    always_comb begin
        rdDataA = readReg(mapAddr(rdAddrA, rp));
        rdDataB = readReg(mapAddr(rdAddrB, rp));
    end

    assign wrAddrMapped = mapAddr(wrAddr, rp);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rp    <= 4'h0;
            flags <= 8'h0;
            port2 <= 8'h0;
        end else begin
            if (flagsWr) begin
                flags <= flagsIn;
            end
            // explicit write to FC beats the ALU flags
            if (wrEn && wrAddrMapped == `Z8_FLAGS_REG) begin
                flags <= wrData;
            end
            if (wrEn && wrAddrMapped == `Z8_RP_REG) begin
                rp <= wrData[7:4];
            end
            if (wrEn && wrAddrMapped == `Z8_PORT2_REG) begin
                port2 <= wrData;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn && wrAddrMapped < `Z8_REG_COUNT) begin
            regs[wrAddrMapped[regIdxWidth-1:0]] <= wrData;
        end
    end

endmodule

`default_nettype wire

// File: hdl/z8Sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "z8core_defines.svh"

module z8Sequencer (
    input  wire                     clk,
    input  wire                     rstN,
    input  wire z8CorePkg::byteT    progData,
    input  wire z8CorePkg::byteT    flags,
    input  wire z8CorePkg::byteT    rdDataA,
    input  wire z8CorePkg::byteT    rdDataB,
    input  wire z8CorePkg::byteT    aluResult,
    output logic                    progStrobe,
    output logic                    pcIncr,
    output logic                    pcBranch,
    output z8CorePkg::byteT         branchOffset,
    output z8CorePkg::regAddrT      rdAddrA,
    output z8CorePkg::regAddrT      rdAddrB,
    output z8CorePkg::regAddrT      wrAddr,
    output logic                    wrEn,
    output logic                    flagsWr,
    output z8CorePkg::byteT         aluA,
    output z8CorePkg::byteT         aluB,
    output z8IsaPkg::aluOpT         aluOp
);
    import z8CorePkg::*;
    import z8IsaPkg::*;

    seqStateT state;
    seqStateT stateNext;
    byteT     instr;
    byteT     second;
    nibbleT   instrH;
    nibbleT   instrL;
    nibbleT   secondH;
    nibbleT   secondL;
    aluOpT    miscOp;
    logic     isSize1;
    logic     isSize2;
    logic     isAluRR;
    logic     isCp;
    logic     isLdWork;
    logic     isLdReg;
    logic     isInc;
    logic     isDjnz;
    logic     isJr;
    logic     isFlagOp;
    logic     condBase;
    logic     takeBranch;

    assign instrH  = instr[7:4];
    assign instrL  = instr[3:0];
    assign secondH = second[7:4];
    assign secondL = second[3:0];

    // length from the column: E,F one byte, 4-7 and D three bytes
    assign isSize1 = (instrL[3:1] == 3'b111);
    assign isSize2 = !isSize1 && !(instrL[3:2] == 2'b01 || instrL == 4'hD);

    assign isAluRR  = (instrL == colAluRR) && (instrH inside {[4'h0:4'h5], 4'hA, 4'hB});
    assign isCp     = (aluOpT'(instrH) == aluCp);
    assign isLdWork = (instrL == colLdIm);
    assign isLdReg  = (instr == opLdRIm);
    assign isInc    = (instrL == colInc);
    assign isDjnz   = (instrL == colDjnz);
    assign isJr     = (instrL == colJr);
    assign isFlagOp = (instrL == colMisc) && (instrH inside {miscRcf, miscScf, miscCcf});

    always_comb begin
        case (instrH)
            miscRcf: miscOp = aluRcf;
            miscScf: miscOp = aluScf;
            miscCcf: miscOp = aluCcf;
            default: miscOp = aluLd;
        endcase
    end

    always_comb begin
        case (condCodeT'({1'b0, instrH[2:0]}))
            ccLt:    condBase = flags[flagS] ^ flags[flagV];
            ccLe:    condBase = (flags[flagS] ^ flags[flagV]) | flags[flagZ];
            ccUle:   condBase = flags[flagC] | flags[flagZ];
            ccOv:    condBase = flags[flagV];
            ccMi:    condBase = flags[flagS];
            ccZ:     condBase = flags[flagZ];
            ccC:     condBase = flags[flagC];
            default: condBase = 1'b0;
        endcase
    end

    // upper eight codes are the negated lower eight
    assign takeBranch = condBase ^ instrH[3];

    assign progStrobe = (state == fetch) || (state == wait2 && !isSize1) || (state == wait3);
    assign pcIncr     = state inside {readInstr, read2, read3};
    assign pcBranch   = (state == decode && isJr && takeBranch)
                      || (state == djnzBranch && aluResult != 8'h0);
    assign branchOffset = second;

    // dst r in aluOp2, otherwise the r in the opcode high nibble
    assign rdAddrA = {`Z8_WORKING_PREFIX, (state == aluOp2) ? secondH : instrH};
    assign rdAddrB = {`Z8_WORKING_PREFIX, secondL};
    assign wrAddr  = isLdReg ? second : {`Z8_WORKING_PREFIX, isAluRR ? secondH : instrH};

    assign wrEn = (state == decode && (isLdWork || isLdReg))
                || (state == aluOp3 && !(isAluRR && isCp))
                || (state == djnzBranch);
    assign flagsWr = (state == decode && isFlagOp) || (state == aluOp3);

    always_comb begin
        stateNext = state;
        case (state)
            fetch:      stateNext = readInstr;
            readInstr:  stateNext = wait2;
            wait2:      stateNext = isSize1 ? decode : read2;
            read2:      stateNext = isSize2 ? decode : wait3;
            wait3:      stateNext = read3;
            read3:      stateNext = decode;
            decode: begin
                if (isAluRR) begin
                    stateNext = aluOp1;
                end else if (isInc) begin
                    stateNext = incOp;
                end else if (isDjnz) begin
                    stateNext = djnzDec;
                end else begin
                    stateNext = fetch;
                end
            end
            aluOp1:     stateNext = aluOp2;
            aluOp2:     stateNext = aluOp3;
            incOp:      stateNext = aluOp3;
            djnzDec:    stateNext = djnzBranch;
            default:    stateNext = fetch;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= fetch;
            aluOp <= aluLd;
        end else begin
            state <= stateNext;
            case (state)
                wait2:   aluOp <= (instrL == colMisc) ? miscOp : aluLd;
                read2:   aluOp <= aluLd;
                read3:   aluOp <= aluLd;
                decode: begin
                    if (isAluRR) begin
                        aluOp <= aluOpT'(instrH);
                    end else if (isInc) begin
                        aluOp <= aluInc;
                    end else if (isDjnz) begin
                        aluOp <= aluDec;
                    end
                end
                default: ;
            endcase
        end
    end

    // last immediate byte lands in aluA so a load writes at decode
    always_ff @(posedge clk) begin
        case (state)
            readInstr: instr <= progData;
            read2: begin
                second <= progData;
                aluA   <= progData;
            end
            read3:   aluA <= progData;
            aluOp1:  aluB <= rdDataB;
            aluOp2:  aluA <= rdDataA;
            incOp:   aluA <= rdDataA;
            djnzDec: aluA <= rdDataA;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/z8core_defines.svh
`ifndef Z8CORE_DEFINES_SVH
`define Z8CORE_DEFINES_SVH

// program memory address width
`define Z8_PROG_ADDR_WIDTH 16

// general registers 00..7F
`define Z8_REG_COUNT 128

// first fetch address after reset
`define Z8_RESET_PC 16'h000C

// special register addresses
`define Z8_PORT2_REG 8'h02
`define Z8_FLAGS_REG 8'hFC
`define Z8_RP_REG 8'hFD

// high nibble that selects a working register
`define Z8_WORKING_PREFIX 4'hE

`endif

// File: test/z8CoreTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "z8core_defines.svh"

module z8CoreTb;
    import z8CorePkg::*;

    localparam int resetCycles = 16;
    localparam int romSize     = 1 << `Z8_PROG_ADDR_WIDTH;

    logic     clk;
    logic     rstN;
    byteT     progData;
    progAddrT progAddr;
    logic     progStrobe;
    byteT     port2;

    byteT     rom [0:romSize-1];
    logic     readPending;
    progAddrT readAddr;

    // expected strobe addresses and port2 values, in order
    progAddrT addrQ [$];
    byteT     port2Q [$];
    string    port2NameQ [$];

    // reference model state
    byteT     mRegs [0:255];
    nibbleT   mRp;
    logic     mC;
    logic     mZ;
    logic     mS;
    byteT     mLastPort2;

    int       instrCount;
    int       cycleLimit;
    int       cycles;
    int       tbErrors;
    byteT     lastPort2;

    z8Core dut_i (
        .clk        (clk),
        .rstN       (rstN),
        .progData   (progData),
        .progAddr   (progAddr),
        .progStrobe (progStrobe),
        .port2      (port2)
    );

    bind z8Core z8CoreTb_properties props_i (
        .clk        (clk),
        .rstN       (rstN),
        .progAddr   (progAddr),
        .progStrobe (progStrobe),
        .port2      (port2)
    );

    always #2 clk = ~clk;

    task automatic reportCounts();
        $display("Errors: %0d testbench, %0d properties", tbErrors, dut_i.props_i.failCount);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("Timeout: program did not reach its end within %0d cycles", cycleLimit);
            reportCounts();
            $display("Simulation failed");
            $finish;
        end
    end

    // ROM answers a strobe with the byte one cycle later
    always @(posedge clk) begin
        if (readPending) begin
            #1;
            progData = rom[readAddr];
        end
    end

    always @(negedge clk) begin : sampleOutputs
        progAddrT wantAddr;
        byteT     wantPort2;
        string    name;
        readPending = progStrobe;
        readAddr    = progAddr;
        if (rstN && progStrobe && addrQ.size() > 0) begin
            wantAddr = addrQ.pop_front();
            fetchAddr: assert (progAddr == wantAddr) else begin
                tbErrors++;
                $display("Fail fetch: expected %h, actual %h", wantAddr, progAddr);
            end
        end
        if (rstN && port2 != lastPort2) begin
            extraWrite: assert (port2Q.size() > 0) else begin
                tbErrors++;
                $display("port2 changed to %h although no further write was expected", port2);
            end
            if (port2Q.size() > 0) begin
                wantPort2 = port2Q.pop_front();
                name      = port2NameQ.pop_front();
                port2Value: assert (port2 == wantPort2) else begin
                    tbErrors++;
                    $display("Fail port2 after %s: expected %h, actual %h",
                             name, wantPort2, port2);
                end
            end
            lastPort2 = port2;
        end
    end

    function automatic regAddrT mapReg(regAddrT addr);
        if (addr[7:4] == `Z8_WORKING_PREFIX) begin
            return {mRp, addr[3:0]};
        end
        return addr;
    endfunction

    function automatic byteT readModel(regAddrT addr);
        regAddrT phys;
        phys = mapReg(addr);
        if (phys == `Z8_RP_REG) begin
            return {mRp, 4'h0};
        end
        return (phys < `Z8_REG_COUNT) ? mRegs[phys] : 8'h00;
    endfunction

    task automatic writeModel(regAddrT addr, byteT value, string name);
        regAddrT phys;
        phys = mapReg(addr);
        if (phys == `Z8_RP_REG) begin
            mRp = value[7:4];
        end
        if (phys < `Z8_REG_COUNT) begin
            mRegs[phys] = value;
        end
        // only a change of port2 is visible
        if (phys == `Z8_PORT2_REG && value != mLastPort2) begin
            port2Q.push_back(value);
            port2NameQ.push_back(name);
            mLastPort2 = value;
        end
    endtask

    function automatic string opName(nibbleT op);
        case (op)
            4'h0: return "add";
            4'h1: return "adc";
            4'h2: return "sub";
            4'h3: return "sbc";
            4'h4: return "or";
            4'h5: return "and";
            4'hA: return "cp";
            default: return "xor";
        endcase
    endfunction

    task automatic aluModel(nibbleT op, byteT dst, byteT src, output byteT res);
        int full;
        int cin;
        cin = (op == 4'h1 || op == 4'h3) ? int'(mC) : 0;
        case (op)
            4'h0, 4'h1: begin
                full = int'(dst) + int'(src) + cin;
                mC   = (full > 255);
            end
            4'h2, 4'h3, 4'hA: begin
                full = int'(dst) - int'(src) - cin;
                mC   = (full < 0);
            end
            4'h4: full = int'(dst | src);
            4'h5: full = int'(dst & src);
            default: full = int'(dst ^ src);
        endcase
        res = byteT'(full);
        mZ  = (res == 8'h00);
        mS  = res[7];
    endtask

    // walks the program from the reset address until the jr-to-self
    task automatic runModel();
        progAddrT pc;
        progAddrT next;
        byteT     op;
        byteT     b2;
        byteT     b3;
        byteT     res;
        nibbleT   hi;
        nibbleT   lo;
        int       len;
        int       i;
        logic     cond;
        logic     halted;
        pc     = `Z8_RESET_PC;
        halted = 1'b0;
        while (!halted && instrCount < 1000) begin
            op = rom[pc];
            b2 = rom[pc + progAddrT'(1)];
            b3 = rom[pc + progAddrT'(2)];
            hi = op[7:4];
            lo = op[3:0];
            if (lo >= 4'hE) begin
                len = 1;
            end else if ((lo >= 4'h4 && lo <= 4'h7) || lo == 4'hD) begin
                len = 3;
            end else begin
                len = 2;
            end
            for (i = 0; i < len; i++) begin
                addrQ.push_back(pc + progAddrT'(i));
            end
            instrCount++;
            next = pc + progAddrT'(len);
            if (op == 8'hE6) begin
                writeModel(b2, b3, "ld R,#im");
            end else if (lo == 4'hC) begin
                writeModel({4'hE, hi}, b2, "ld r,#im");
            end else if (lo == 4'h2 && (hi <= 4'h5 || hi == 4'hA || hi == 4'hB)) begin
                aluModel(hi, readModel({4'hE, b2[7:4]}), readModel({4'hE, b2[3:0]}), res);
                if (hi != 4'hA) begin
                    writeModel({4'hE, b2[7:4]}, res, opName(hi));
                end
            end else if (lo == 4'hE) begin
                res = readModel({4'hE, hi}) + 8'h01;
                mZ  = (res == 8'h00);
                mS  = res[7];
                writeModel({4'hE, hi}, res, "inc");
            end else if (lo == 4'hA) begin
                res = readModel({4'hE, hi}) - 8'h01;
                writeModel({4'hE, hi}, res, "djnz");
                if (res != 8'h00) begin
                    next = next + {{8{b2[7]}}, b2};
                end
            end else if (lo == 4'hB) begin
                // lt, le and ov need V and stay unused here
                case (hi[2:0])
                    3'd3: cond = mC | mZ;
                    3'd5: cond = mS;
                    3'd6: cond = mZ;
                    3'd7: cond = mC;
                    default: cond = 1'b0;
                endcase
                if (cond ^ hi[3]) begin
                    halted = ((next + {{8{b2[7]}}, b2}) == pc);
                    next   = next + {{8{b2[7]}}, b2};
                end
            end else if (lo == 4'hF) begin
                if (hi == 4'hC) begin
                    mC = 1'b0;
                end else if (hi == 4'hD) begin
                    mC = 1'b1;
                end else if (hi == 4'hE) begin
                    mC = ~mC;
                end
            end
            pc = next;
        end
        // one more fetch of the halt loop ends the run
        addrQ.push_back(pc);
    endtask

    task automatic loadProgram();
        byteT code [$];
        int   k;
        code = {
            8'hE6, 8'h02, 8'h5A,  // ld 02,#5A
            8'hE6, 8'hFD, 8'h00,  // ld FD,#00
            8'h2C, 8'h3C,         // ld r2,#3C
            8'h3C, 8'h14,         // ld r3,#14
            8'h4C, 8'h0F,         // ld r4,#0F
            8'h5C, 8'hF0,         // ld r5,#F0
            8'h6C, 8'h03,         // ld r6,#03
            8'hFF,                // nop
            8'h02, 8'h23,         // add r2,r3
            8'h22, 8'h24,         // sub r2,r4
            8'h52, 8'h23,         // and r2,r3
            8'h42, 8'h23,         // or r2,r3
            8'hB2, 8'h24,         // xor r2,r4
            8'hA2, 8'h23,         // cp r2,r3
            8'hDF,                // scf
            8'h12, 8'h23,         // adc r2,r3
            8'h02, 8'h25,         // add r2,r5 with carry out
            8'hEF,                // ccf
            8'h12, 8'h23,         // adc r2,r3
            8'hCF,                // rcf
            8'h32, 8'h24,         // sbc r2,r4
            8'hA2, 8'h22,         // cp r2,r2
            8'h6B, 8'h02,         // jr z,+2
            8'h2C, 8'hEE,
            8'hEB, 8'h02,         // jr nz,+2
            8'h2C, 8'h71,
            8'h0B, 8'h02,         // jr false,+2
            8'h2C, 8'h72,
            8'h8B, 8'h02,         // jr true,+2
            8'h2C, 8'hEE,
            8'hA2, 8'h23,         // cp r2,r3
            8'hEB, 8'h02,         // jr nz,+2
            8'h2C, 8'hEE,
            8'h6B, 8'h02,         // jr z,+2
            8'h2C, 8'h73,
            8'h2E,                // loop: inc r2
            8'h6A, 8'hFD,         // djnz r6,loop
            8'h8B, 8'hFE          // jr true,self
        };
        for (k = 0; k < code.size(); k++) begin
            rom[`Z8_RESET_PC + k] = code[k];
        end
    endtask

    initial begin : mainFlow
        int i;
        clk         = 1'b0;
        rstN        = 1'b0;
        progData    = 8'h00;
        readPending = 1'b0;
        readAddr    = '0;
        cycles      = 0;
        cycleLimit  = 0;
        tbErrors    = 0;
        instrCount  = 0;
        lastPort2   = 8'h00;
        mRp         = 4'h0;
        mC          = 1'b0;
        mZ          = 1'b0;
        mS          = 1'b0;
        mLastPort2  = 8'h00;
        for (i = 0; i < 256; i++) begin
            mRegs[i] = 8'h00;
        end
        for (i = 0; i < romSize; i++) begin
            rom[i] = byteT'(i[15:8] ^ i[7:0] ^ 8'h5A);
        end
        loadProgram();
        runModel();
        cycleLimit = 10 * instrCount * 8;

        repeat (resetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
        resetPort2: assert (port2 == 8'h00) else begin
            tbErrors++;
            $display("Fail reset: expected %h, actual %h", 8'h00, port2);
        end

        while (addrQ.size() > 0) @(posedge clk);
        missingWrites: assert (port2Q.size() == 0) else begin
            tbErrors++;
            $display("%0d expected port2 writes never happened", port2Q.size());
        end

        reportCounts();
        if (tbErrors == 0 && dut_i.props_i.failCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/z8CoreTb_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "z8core_defines.svh"

module z8CoreTb_properties (
    input wire                      clk,
    input wire                      rstN,
    input wire z8CorePkg::progAddrT progAddr,
    input wire                      progStrobe,
    input wire z8CorePkg::byteT     port2
);
    import z8CorePkg::*;

    int failCount = 0;

    // first cycle out of reset fetches the reset address
    resetFetch: assert property (@(posedge clk)
        $rose(rstN) |-> progStrobe && progAddr == `Z8_RESET_PC)
        else begin
            failCount++;
            $error("first fetch after reset is not at the reset address");
        end

    port2Cleared: assert property (@(posedge clk)
        !rstN |-> port2 == 8'h00)
        else begin
            failCount++;
            $error("port2 is not zero while reset is active");
        end

    // a read strobe lasts one cycle
    singleStrobe: assert property (@(posedge clk) disable iff (!rstN)
        progStrobe |=> !progStrobe)
        else begin
            failCount++;
            $error("fetch strobe held for two cycles");
        end

    // strobes two cycles apart are operand bytes of one instruction
    operandAddr: assert property (@(posedge clk) disable iff (!rstN)
        progStrobe && $past(progStrobe, 2) && $past(rstN, 2)
        |-> progAddr == $past(progAddr, 2) + progAddrT'(1))
        else begin
            failCount++;
            $error("operand byte fetched from a non-consecutive address");
        end

    knownOutputs: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown({progStrobe, progAddr, port2}))
        else begin
            failCount++;
            $error("core output is unknown");
        end

    // port2 only moves as an instruction ends, together with the next fetch
    port2AtFetch: assert property (@(posedge clk) disable iff (!rstN)
        !$stable(port2) |-> progStrobe)
        else begin
            failCount++;
            $error("port2 changed outside the end of an instruction");
        end

endmodule

`default_nettype wire

// File: z8core.f
+incdir+hdl
hdl/z8IsaPkg.sv
hdl/z8CorePkg.sv
hdl/z8Alu.sv
hdl/z8RegFile.sv
hdl/z8ProgCounter.sv
hdl/z8Sequencer.sv
hdl/z8Core.sv
test/z8CoreTb_properties.sv
test/z8CoreTb.sv
